// File: logic/dataCache_cfg.svh
`ifndef DATACACHE_CFG_SVH
`define DATACACHE_CFG_SVH

// Byte address width of both buses
`define DC_ADDR_BITS 32

// Sets per way and 32-bit words per line
`define DC_SETS 16
`define DC_WORDS 4

// Address field widths
`define DC_INDEX_BITS ($clog2(`DC_SETS))
`define DC_WORD_BITS ($clog2(`DC_WORDS))
`define DC_OFFSET_BITS (`DC_WORD_BITS + 2)
`define DC_TAG_BITS (`DC_ADDR_BITS - `DC_INDEX_BITS - `DC_OFFSET_BITS)

`endif

// File: logic/dataCachePkg.sv
`include "dataCache_cfg.svh"

package dataCachePkg;

  // One tag store entry per way and set
  typedef struct packed {
    logic valid;
    logic dirty;
    logic [`DC_TAG_BITS-1:0] tag;
  } tagEntry;

  // A full cache line, word 0 at the lowest address
  typedef logic [`DC_WORDS-1:0][31:0] lineData;

  typedef logic [`DC_INDEX_BITS-1:0] setIndex;
  typedef logic [`DC_WORD_BITS-1:0] wordIndex;

  // Controller states
  typedef enum logic [2:0] {
    idle,
    lookup,
    writeBack,
    refill,
    respond,
    uncached,
    flushScan,
    flushWrite
  } ctrlState;

endpackage

// File: logic/cpuPort.sv
`include "dataCache_cfg.svh"

module cpuPort (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cpuCyc,
  input  logic                     cpuStb,
  input  logic                     cpuWe,
  input  logic [3:0]               cpuSel,
  input  logic [`DC_ADDR_BITS-1:0] cpuAdr,
  input  logic [31:0]              cpuDatW,
  output logic [31:0]              cpuDatR,
  output logic                     cpuAck,
  output logic                     reqValid,
  output logic                     reqWe,
  output logic [3:0]               reqSel,
  output logic [`DC_ADDR_BITS-1:0] reqAdr,
  output logic [31:0]              reqDat,
  input  logic                     respDone,
  input  logic [31:0]              respDat
);

  logic accept;

  // New request only when idle and not in our own ack cycle
  assign accept = cpuCyc && cpuStb && !reqValid && !cpuAck;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      reqValid <= 1'b0;
      cpuAck   <= 1'b0;
    end else begin
      cpuAck <= respDone;
      if (respDone) begin
        reqValid <= 1'b0;
      end else if (accept) begin
        reqValid <= 1'b1;
      end
    end
  end

  // Request fields and read data
  always_ff @(posedge clk) begin
    if (accept) begin
      reqWe  <= cpuWe;
      reqSel <= cpuSel;
      reqAdr <= cpuAdr;
      reqDat <= cpuDatW;
    end
    if (respDone) begin
      cpuDatR <= respDat;
    end
  end

  // Processor must hold its cycle until it sees the ack
  ackInsideCycle: assert property (
    @(posedge clk) disable iff (reset) cpuAck |-> cpuCyc
  );

endmodule

// File: logic/wayRam.sv
`include "dataCache_cfg.svh"

module wayRam #(
  parameter type entryType = logic [31:0],
  parameter int  depth     = `DC_SETS
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] wIdx,
  input  entryType                 wData,
  input  logic [$clog2(depth)-1:0] rIdx,
  output entryType                 rData
);

  entryType mem [depth];

  // Cleared on reset so every valid bit starts low
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[wIdx] <= wData;
    end
  end

  // Asynchronous read
  assign rData = mem[rIdx];

endmodule

// File: logic/cacheWays.sv
`include "dataCache_cfg.svh"

module cacheWays (
  input  logic                    clk,
  input  logic                    reset,
  input  dataCachePkg::setIndex   idx,
  input  logic [`DC_TAG_BITS-1:0] lookupTag,
  input  logic [1:0]              tagWe,
  input  logic [1:0]              dataWe,
  input  dataCachePkg::tagEntry   tagIn,
  input  dataCachePkg::lineData   lineIn,
  input  logic                    lruWe,
  input  logic                    lruIn,
  output dataCachePkg::tagEntry   tag0,
  output dataCachePkg::tagEntry   tag1,
  output dataCachePkg::lineData   line0,
  output dataCachePkg::lineData   line1,
  output logic                    hit,
  output logic                    hitWay,
  output logic                    lru
);

  dataCachePkg::tagEntry tags [2];
  dataCachePkg::lineData lines [2];
  logic [1:0]            wayHit;
  logic [`DC_SETS-1:0]   lruBits;

  for (genvar w = 0; w < 2; w++) begin : gWay
    wayRam #(.entryType(dataCachePkg::tagEntry), .depth(`DC_SETS)) tagRam (
      .clk   (clk),
      .reset (reset),
      .we    (tagWe[w]),
      .wIdx  (idx),
      .wData (tagIn),
      .rIdx  (idx),
      .rData (tags[w])
    );

    wayRam #(.entryType(dataCachePkg::lineData), .depth(`DC_SETS)) dataRam (
      .clk   (clk),
      .reset (reset),
      .we    (dataWe[w]),
      .wIdx  (idx),
      .wData (lineIn),
      .rIdx  (idx),
      .rData (lines[w])
    );

    assign wayHit[w] = tags[w].valid && (tags[w].tag == lookupTag);
  end

  assign tag0   = tags[0];
  assign tag1   = tags[1];
  assign line0  = lines[0];
  assign line1  = lines[1];
  assign hit    = |wayHit;
  assign hitWay = wayHit[1];

  // Per set, the way to evict next
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (lruWe) begin
      lruBits[idx] <= lruIn;
    end
  end

  assign lru = lruBits[idx];

  // Refill never installs a line that is already present in the other way
  noDoubleHit: assert property (
    @(posedge clk) disable iff (reset) !(&wayHit)
  );

endmodule

// File: logic/cacheController.sv
`include "dataCache_cfg.svh"

module cacheController (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cacheEnable,
  input  logic                     flushReq,
  output logic                     flushBusy,
  input  logic                     reqValid,
  input  logic                     reqWe,
  input  logic [3:0]               reqSel,
  input  logic [`DC_ADDR_BITS-1:0] reqAdr,
  input  logic [31:0]              reqDat,
  output logic                     respDone,
  output logic [31:0]              respDat,
  output dataCachePkg::setIndex    idx,
  output logic [`DC_TAG_BITS-1:0]  lookupTag,
  output logic [1:0]               tagWe,
  output logic [1:0]               dataWe,
  output dataCachePkg::tagEntry    tagIn,
  output dataCachePkg::lineData    lineIn,
  output logic                     lruWe,
  output logic                     lruIn,
  input  dataCachePkg::tagEntry    tag0,
  input  dataCachePkg::tagEntry    tag1,
  input  dataCachePkg::lineData    line0,
  input  dataCachePkg::lineData    line1,
  input  logic                     hit,
  input  logic                     hitWay,
  input  logic                     lru,
  output logic                     opStart,
  output logic                     opWrite,
  output logic                     opSingle,
  output logic [`DC_ADDR_BITS-1:0] opAdr,
  output dataCachePkg::lineData    opLine,
  output logic [3:0]               opSel,
  input  logic                     opDone,
  input  dataCachePkg::lineData    fillLine
);

  dataCachePkg::ctrlState state, nextState;
  dataCachePkg::setIndex  flushIdx;
  dataCachePkg::wordIndex reqWord;
  dataCachePkg::tagEntry  selTag;
  dataCachePkg::lineData  selLine;
  logic victim, pick, way, flushWay, opPending;
  logic dirty0, dirty1;

  function automatic logic [31:0] mergeWord(input logic [31:0] old, input logic [31:0] data,
                                            input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  assign reqWord   = reqAdr[2 +: `DC_WORD_BITS];
  assign lookupTag = reqAdr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];
  assign flushBusy = (state == dataCachePkg::flushScan) || (state == dataCachePkg::flushWrite);
  assign idx       = flushBusy ? flushIdx : reqAdr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
  assign respDone  = state == dataCachePkg::respond;
  assign dirty0    = tag0.valid && tag0.dirty;
  assign dirty1    = tag1.valid && tag1.dirty;

  // Victim is an empty way first, then the LRU way
  assign pick = tag0.valid ? (tag1.valid ? lru : 1'b1) : 1'b0;

  // Way that the current state works on
  always_comb begin
    case (state)
      dataCachePkg::lookup:     way = hit ? hitWay : pick;
      dataCachePkg::flushScan:  way = ~dirty0;
      dataCachePkg::flushWrite: way = flushWay;
      default:                  way = victim;
    endcase
  end

  assign selTag  = way ? tag1 : tag0;
  assign selLine = way ? line1 : line0;

  always_comb begin
    nextState = state;
    tagWe     = '0;
    dataWe    = '0;
    tagIn     = selTag;
    lineIn    = selLine;
    lruWe     = 1'b0;
    lruIn     = ~way;
    opStart   = 1'b0;
    opWrite   = 1'b0;
    opSingle  = 1'b0;
    opAdr     = {lookupTag, idx, {`DC_OFFSET_BITS{1'b0}}};
    opLine    = selLine;
    opSel     = 4'hf;
    case (state)
      dataCachePkg::idle: begin
        if (reqValid && cacheEnable) begin
          nextState = dataCachePkg::lookup;
        end else if (reqValid) begin
          // Straight to memory as one word
          opStart   = 1'b1;
          opWrite   = reqWe;
          opSingle  = 1'b1;
          opAdr     = reqAdr;
          opLine    = {`DC_WORDS{reqDat}};
          opSel     = reqSel;
          nextState = dataCachePkg::uncached;
        end else if (flushReq) begin
          nextState = dataCachePkg::flushScan;
        end
      end
      dataCachePkg::lookup: begin
        if (hit) begin
          lruWe = 1'b1;
          if (reqWe) begin
            lineIn[reqWord] = mergeWord(selLine[reqWord], reqDat, reqSel);
            tagIn.dirty     = 1'b1;
            tagWe[way]      = 1'b1;
            dataWe[way]     = 1'b1;
          end
          nextState = dataCachePkg::respond;
        end else begin
          opStart = 1'b1;
          if (selTag.valid && selTag.dirty) begin
            opWrite   = 1'b1;
            opAdr     = {selTag.tag, idx, {`DC_OFFSET_BITS{1'b0}}};
            nextState = dataCachePkg::writeBack;
          end else begin
            nextState = dataCachePkg::refill;
          end
        end
      end
      dataCachePkg::writeBack: begin
        if (opDone) begin
          opStart   = 1'b1;
          nextState = dataCachePkg::refill;
        end
      end
      dataCachePkg::refill: begin
        // Install clean, then look up again to apply the request
        if (opDone) begin
          tagWe[way]  = 1'b1;
          dataWe[way] = 1'b1;
          tagIn.valid = 1'b1;
          tagIn.dirty = 1'b0;
          tagIn.tag   = lookupTag;
          lineIn      = fillLine;
          nextState   = dataCachePkg::lookup;
        end
      end
      dataCachePkg::respond: nextState = dataCachePkg::idle;
      dataCachePkg::uncached: begin
        if (opDone) nextState = dataCachePkg::respond;
      end
      dataCachePkg::flushScan: begin
        if (dirty0 || dirty1) begin
          opStart   = 1'b1;
          opWrite   = 1'b1;
          opAdr     = {selTag.tag, idx, {`DC_OFFSET_BITS{1'b0}}};
          nextState = dataCachePkg::flushWrite;
        end else if (flushIdx == dataCachePkg::setIndex'(`DC_SETS - 1)) begin
          nextState = dataCachePkg::idle;
        end
      end
      dataCachePkg::flushWrite: begin
        // Line stays valid and only its dirty bit clears before the set is scanned again
        if (opDone) begin
          tagWe[way]  = 1'b1;
          tagIn.dirty = 1'b0;
          nextState   = dataCachePkg::flushScan;
        end
      end
      default: nextState = dataCachePkg::idle;
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state     <= dataCachePkg::idle;
      victim    <= 1'b0;
      flushWay  <= 1'b0;
      flushIdx  <= '0;
      opPending <= 1'b0;
    end else begin
      state <= nextState;
      if (state == dataCachePkg::lookup && !hit) victim <= pick;
      if (nextState == dataCachePkg::flushWrite && state == dataCachePkg::flushScan) begin
        flushWay <= way;
      end
      if (state == dataCachePkg::idle) begin
        flushIdx <= '0;
      end else if (state == dataCachePkg::flushScan && nextState == dataCachePkg::flushScan) begin
        flushIdx <= flushIdx + 1'b1;
      end
      if (opStart) begin
        opPending <= 1'b1;
      end else if (opDone) begin
        opPending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == dataCachePkg::lookup && hit) begin
      respDat <= selLine[reqWord];
    end else if (state == dataCachePkg::uncached && opDone) begin
      respDat <= fillLine[reqWord];
    end
  end

  // Bus master takes a new operation only once the previous one is done
  oneOpAtATime: assert property (
    @(posedge clk) disable iff (reset) opStart |-> (!opPending || opDone)
  );

  respWithReq: assert property (
    @(posedge clk) disable iff (reset) respDone |-> reqValid
  );

endmodule

// File: logic/memBusMaster.sv
`include "dataCache_cfg.svh"

module memBusMaster (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     opStart,
  input  logic                     opWrite,
  input  logic                     opSingle,
  input  logic [`DC_ADDR_BITS-1:0] opAdr,
  input  dataCachePkg::lineData    opLine,
  input  logic [3:0]               opSel,
  output logic                     opDone,
  output dataCachePkg::lineData    fillLine,
  output logic                     memCyc,
  output logic                     memStb,
  output logic                     memWe,
  output logic [3:0]               memSel,
  output logic [`DC_ADDR_BITS-1:0] memAdr,
  output logic [31:0]              memDatW,
  input  logic [31:0]              memDatR,
  input  logic                     memAck
);

  logic                     active, isWrite, isSingle;
  logic [`DC_ADDR_BITS-1:0] baseAdr;
  logic [3:0]               selReg;
  dataCachePkg::wordIndex   count;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      active   <= 1'b0;
      isWrite  <= 1'b0;
      isSingle <= 1'b0;
      opDone   <= 1'b0;
      count    <= '0;
    end else begin
      opDone <= 1'b0;
      if (opStart) begin
        active   <= 1'b1;
        isWrite  <= opWrite;
        isSingle <= opSingle;
        // A single word starts at its own offset in the line
        count    <= opSingle ? opAdr[2 +: `DC_WORD_BITS] : '0;
      end else if (active && memAck) begin
        if (isSingle || count == dataCachePkg::wordIndex'(`DC_WORDS - 1)) begin
          active <= 1'b0;
          opDone <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

  // Address, select and line buffer
  always_ff @(posedge clk) begin
    if (opStart) begin
      baseAdr  <= opAdr;
      selReg   <= opSel;
      fillLine <= opLine;
    end else if (active && memAck && !isWrite) begin
      fillLine[count] <= memDatR;
    end
  end

  assign memCyc  = active;
  assign memStb  = active;
  assign memWe   = active && isWrite;
  assign memSel  = isSingle ? selReg : 4'hf;
  assign memAdr  = {baseAdr[`DC_ADDR_BITS-1:`DC_OFFSET_BITS], count, baseAdr[1:0]};
  assign memDatW = fillLine[count];

  // Slave acks only a strobed word cycle
  ackInStb: assert property (
    @(posedge clk) disable iff (reset) memAck |-> memStb
  );

  // Address held until the slave acks
  adrStable: assert property (
    @(posedge clk) disable iff (reset) memStb && !memAck |=> $stable(memAdr)
  );

endmodule

// File: logic/dataCache.sv
`include "dataCache_cfg.svh"

module dataCache (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cpuCyc,
  input  logic                     cpuStb,
  input  logic                     cpuWe,
  input  logic [3:0]               cpuSel,
  input  logic [`DC_ADDR_BITS-1:0] cpuAdr,
  input  logic [31:0]              cpuDatW,
  output logic [31:0]              cpuDatR,
  output logic                     cpuAck,
  output logic                     memCyc,
  output logic                     memStb,
  output logic                     memWe,
  output logic [3:0]               memSel,
  output logic [`DC_ADDR_BITS-1:0] memAdr,
  output logic [31:0]              memDatW,
  input  logic [31:0]              memDatR,
  input  logic                     memAck,
  input  logic                     cacheEnable,
  input  logic                     flushReq,
  output logic                     flushBusy
);

  // Processor request path
  logic                     reqValid, reqWe, respDone;
  logic [3:0]               reqSel;
  logic [`DC_ADDR_BITS-1:0] reqAdr;
  logic [31:0]              reqDat, respDat;

  // Array controls
  dataCachePkg::setIndex    idx;
  logic [`DC_TAG_BITS-1:0]  lookupTag;
  logic [1:0]               tagWe, dataWe;
  dataCachePkg::tagEntry    tagIn, tag0, tag1;
  dataCachePkg::lineData    lineIn, line0, line1;
  logic                     lruWe, lruIn, hit, hitWay, lru;

  // Memory operations
  logic                     opStart, opWrite, opSingle, opDone;
  logic [`DC_ADDR_BITS-1:0] opAdr;
  dataCachePkg::lineData    opLine, fillLine;
  logic [3:0]               opSel;

  cpuPort cpuPort_i (
    .clk(clk), .reset(reset),
    .cpuCyc(cpuCyc), .cpuStb(cpuStb), .cpuWe(cpuWe), .cpuSel(cpuSel),
    .cpuAdr(cpuAdr), .cpuDatW(cpuDatW), .cpuDatR(cpuDatR), .cpuAck(cpuAck),
    .reqValid(reqValid), .reqWe(reqWe), .reqSel(reqSel), .reqAdr(reqAdr),
    .reqDat(reqDat), .respDone(respDone), .respDat(respDat)
  );

  cacheController cacheController_i (
    .clk(clk), .reset(reset), .cacheEnable(cacheEnable),
    .flushReq(flushReq), .flushBusy(flushBusy),
    .reqValid(reqValid), .reqWe(reqWe), .reqSel(reqSel), .reqAdr(reqAdr),
    .reqDat(reqDat), .respDone(respDone), .respDat(respDat),
    .idx(idx), .lookupTag(lookupTag), .tagWe(tagWe), .dataWe(dataWe),
    .tagIn(tagIn), .lineIn(lineIn), .lruWe(lruWe), .lruIn(lruIn),
    .tag0(tag0), .tag1(tag1), .line0(line0), .line1(line1),
    .hit(hit), .hitWay(hitWay), .lru(lru),
    .opStart(opStart), .opWrite(opWrite), .opSingle(opSingle), .opAdr(opAdr),
    .opLine(opLine), .opSel(opSel), .opDone(opDone), .fillLine(fillLine)
  );

  cacheWays cacheWays_i (
    .clk(clk), .reset(reset), .idx(idx), .lookupTag(lookupTag),
    .tagWe(tagWe), .dataWe(dataWe), .tagIn(tagIn), .lineIn(lineIn),
    .lruWe(lruWe), .lruIn(lruIn), .tag0(tag0), .tag1(tag1),
    .line0(line0), .line1(line1), .hit(hit), .hitWay(hitWay), .lru(lru)
  );

  memBusMaster memBusMaster_i (
    .clk(clk), .reset(reset),
    .opStart(opStart), .opWrite(opWrite), .opSingle(opSingle), .opAdr(opAdr),
    .opLine(opLine), .opSel(opSel), .opDone(opDone), .fillLine(fillLine),
    .memCyc(memCyc), .memStb(memStb), .memWe(memWe), .memSel(memSel),
    .memAdr(memAdr), .memDatW(memDatW), .memDatR(memDatR), .memAck(memAck)
  );

endmodule

// File: verification/memModel.sv
`include "dataCache_cfg.svh"

module memModel #(
  parameter int words = 4096
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     memCyc,
  input  logic                     memStb,
  input  logic                     memWe,
  input  logic [3:0]               memSel,
  input  logic [`DC_ADDR_BITS-1:0] memAdr,
  input  logic [31:0]              memDatW,
  output logic [31:0]              memDatR,
  output logic                     memAck,
  output int                       readCount,
  output int                       writeCount
);

  logic [31:0]              mem [words];
  logic [31:0]              rnd;
  logic                     pending;
  logic [1:0]               waitLeft;
  logic                     finish;
  logic [$clog2(words)-1:0] wordAdr;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  assign wordAdr = memAdr[2 +: $clog2(words)];
  // Edge that ends the wait and raises ack
  assign finish = memCyc && memStb && !memAck && pending && (waitLeft == 2'd0);

  // Contents mix the LCG stream with the word address
  initial begin
    logic [31:0] s;
    s = 32'h06d9_1498;
    for (int i = 0; i < words; i++) begin
      s = lcgNext(s);
      mem[i] = s ^ 32'(i);
    end
  end

  always @(posedge clk, posedge reset) begin
    if (reset) begin
      memAck     <= 1'b0;
      memDatR    <= '0;
      pending    <= 1'b0;
      waitLeft   <= '0;
      rnd        <= 32'h06d9_1498;
      readCount  <= 0;
      writeCount <= 0;
    end else begin
      memAck <= 1'b0;
      if (memCyc && memStb && !memAck) begin
        if (!pending) begin
          // A new request draws 0 to 3 extra wait cycles
          pending  <= 1'b1;
          waitLeft <= rnd[17:16];
          rnd      <= lcgNext(rnd);
        end else if (waitLeft != 2'd0) begin
          waitLeft <= waitLeft - 2'd1;
        end else begin
          pending <= 1'b0;
          memAck  <= 1'b1;
          if (memWe) begin
            writeCount <= writeCount + 1;
          end else begin
            readCount <= readCount + 1;
            memDatR   <= mem[wordAdr];
          end
        end
      end
    end
  end

  // Byte lanes under the select
  always @(posedge clk) begin
    if (finish && memWe) begin
      for (int b = 0; b < 4; b++) begin
        if (memSel[b]) begin
          mem[wordAdr][8*b +: 8] <= memDatW[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: verification/dataCacheTb.sv
`include "dataCache_cfg.svh"

module dataCacheTb;

  localparam int memWords = 4096;
  // Worst miss is a dirty writeback plus a refill
  localparam int worstMiss = 8 * 4 + 10;
  localparam int accessCount = 30;
  localparam int cycleLimit = 16 + 2 * accessCount * worstMiss;

  logic                     clk, reset;
  logic                     cpuCyc, cpuStb, cpuWe, cpuAck;
  logic [3:0]               cpuSel, memSel;
  logic [`DC_ADDR_BITS-1:0] cpuAdr, memAdr;
  logic [31:0]              cpuDatW, cpuDatR, memDatW, memDatR;
  logic                     memCyc, memStb, memWe, memAck;
  logic                     cacheEnable, flushReq, flushBusy;
  int                       readCount, writeCount;

  logic [31:0] refMem [memWords];
  logic [31:0] writtenAdrs [$];
  int          errorCount, checkCount, cycleCount;
  // Edges from the one that samples stb to the one that raises ack
  int          ackDelay;

  dataCache dataCache_i (.*);
  memModel #(.words(memWords)) memModel_i (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == cycleLimit) begin
      $display("Timeout: tests did not finish within %0d cycles", cycleLimit);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] makeAdr(input int tag, input int set, input int word);
    return (32'(tag) << 8) | (32'(set) << 4) | (32'(word) << 2);
  endfunction

  function automatic logic [31:0] applySelect(input logic [31:0] old, input logic [31:0] dat,
                                              input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old & ~mask) | (dat & mask);
  endfunction

  task automatic checkEqual(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic busAccess(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic [31:0] rdata);
    int edges;
    @(posedge clk);
    #1;
    cpuCyc  = 1'b1;
    cpuStb  = 1'b1;
    cpuWe   = we;
    cpuAdr  = adr;
    cpuDatW = dat;
    cpuSel  = sel;
    edges   = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (!cpuAck);
    rdata    = cpuDatR;
    ackDelay = edges - 1;
    // Ack is sampled at the next edge, so the cycle is held until then
    @(posedge clk);
    #1;
    cpuCyc = 1'b0;
    cpuStb = 1'b0;
    cpuWe  = 1'b0;
  endtask

  task automatic cpuRead(input logic [31:0] adr, output logic [31:0] data);
    busAccess(1'b0, adr, 32'h0, 4'hf, data);
  endtask

  task automatic cpuWrite(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] ignored;
    refMem[adr[13:2]] = applySelect(refMem[adr[13:2]], dat, sel);
    writtenAdrs.push_back(adr);
    busAccess(1'b1, adr, dat, sel, ignored);
  endtask

  task automatic readMissThenHit();
    logic [31:0] adr, data;
    int reads, writes;
    adr   = makeAdr(1, 2, 0);
    reads = readCount;
    cpuRead(adr, data);
    checkEqual("readMissThenHit miss data", refMem[adr[13:2]], data);
    checkEqual("readMissThenHit miss reads", 4, readCount - reads);
    adr    = makeAdr(1, 2, 3);
    reads  = readCount;
    writes = writeCount;
    cpuRead(adr, data);
    checkEqual("readMissThenHit hit data", refMem[adr[13:2]], data);
    checkEqual("readMissThenHit hit traffic", 0, (readCount - reads) + (writeCount - writes));
    checkEqual("readMissThenHit hit latency", 3, ackDelay);
  endtask

  task automatic writeHitBytes();
    logic [31:0] adr, data;
    int reads, writes;
    adr    = makeAdr(1, 2, 1);
    reads  = readCount;
    writes = writeCount;
    cpuWrite(adr, 32'hdead_beef, 4'b0101);
    checkEqual("writeHitBytes write latency", 3, ackDelay);
    cpuRead(adr, data);
    checkEqual("writeHitBytes data", refMem[adr[13:2]], data);
    checkEqual("writeHitBytes traffic", 0, (readCount - reads) + (writeCount - writes));
  endtask

  task automatic lruReplacement();
    logic [31:0] adrA, adr, data;
    int writes;
    adrA = makeAdr(3, 5, 0);
    cpuWrite(adrA, 32'h1234_5678, 4'hf);
    writes = writeCount;
    cpuRead(makeAdr(4, 5, 1), data);
    cpuRead(adrA, data);
    checkEqual("lruReplacement touch A", refMem[adrA[13:2]], data);
    // B is the LRU way now and clean
    cpuRead(makeAdr(5, 5, 2), data);
    checkEqual("lruReplacement clean evict", 0, writeCount - writes);
    adr = makeAdr(6, 5, 0);
    cpuRead(adr, data);
    checkEqual("lruReplacement D data", refMem[adr[13:2]], data);
    cpuRead(makeAdr(7, 5, 3), data);
    checkEqual("lruReplacement writeback count", 4, writeCount - writes);
    checkEqual("lruReplacement memory A", refMem[adrA[13:2]], memModel_i.mem[adrA[13:2]]);
  endtask

  task automatic uncachedAccess();
    logic [31:0] adr, data;
    int reads, writes;
    @(posedge clk);
    #1;
    cacheEnable = 1'b0;
    reads  = readCount;
    writes = writeCount;
    adr    = makeAdr(9, 7, 2);
    cpuRead(adr, data);
    checkEqual("uncachedAccess read data", refMem[adr[13:2]], data);
    checkEqual("uncachedAccess read cycles", 1, (readCount - reads) + (writeCount - writes));
    adr = makeAdr(9, 7, 1);
    cpuWrite(adr, 32'hcafe_f00d, 4'b1100);
    checkEqual("uncachedAccess write cycles", 1, writeCount - writes);
    checkEqual("uncachedAccess memory", refMem[adr[13:2]], memModel_i.mem[adr[13:2]]);
    cpuRead(adr, data);
    checkEqual("uncachedAccess readback", refMem[adr[13:2]], data);
    checkEqual("uncachedAccess total reads", 2, readCount - reads);
    cacheEnable = 1'b1;
  endtask

  task automatic flushDirtyLines();
    logic [31:0] adrs [3];
    logic [31:0] adr, data;
    int reads, writes;
    adrs = '{makeAdr(2, 8, 0), makeAdr(3, 8, 3), makeAdr(4, 11, 2)};
    for (int i = 0; i < 3; i++) begin
      cpuWrite(adrs[i], 32'ha5a5_0000 | 32'(i), 4'hf);
    end
    reads  = readCount;
    writes = writeCount;
    @(posedge clk);
    #1;
    flushReq = 1'b1;
    @(posedge clk);
    #1;
    flushReq = 1'b0;
    checkEqual("flushDirtyLines busy", 1, 32'(flushBusy));
    while (flushBusy) begin
      @(posedge clk);
      #1;
    end
    // Set 2 from the write hit test plus three new lines
    checkEqual("flushDirtyLines writes", 4 * 4, writeCount - writes);
    checkEqual("flushDirtyLines reads", 0, readCount - reads);
    foreach (writtenAdrs[i]) begin
      adr = writtenAdrs[i];
      checkEqual("flushDirtyLines memory", refMem[adr[13:2]], memModel_i.mem[adr[13:2]]);
    end
    reads  = readCount;
    writes = writeCount;
    cpuRead(adrs[0], data);
    checkEqual("flushDirtyLines reread", refMem[adrs[0][13:2]], data);
    checkEqual("flushDirtyLines reread traffic", 0, (readCount - reads) + (writeCount - writes));
  endtask

  initial begin
    errorCount  = 0;
    checkCount  = 0;
    cycleCount  = 0;
    ackDelay    = 0;
    clk         = 1'b0;
    reset       = 1'b1;
    cpuCyc      = 1'b0;
    cpuStb      = 1'b0;
    cpuWe       = 1'b0;
    cpuSel      = 4'h0;
    cpuAdr      = '0;
    cpuDatW     = '0;
    cacheEnable = 1'b1;
    flushReq    = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < memWords; i++) begin
      refMem[i] = memModel_i.mem[i];
    end
    checkEqual("reset outputs", 0, 32'({cpuAck, memCyc, memStb, flushBusy}));
    readMissThenHit();
    writeHitBytes();
    lruReplacement();
    uncachedAccess();
    flushDirtyLines();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+logic
logic/dataCachePkg.sv
logic/cpuPort.sv
logic/wayRam.sv
logic/cacheWays.sv
logic/cacheController.sv
logic/memBusMaster.sv
logic/dataCache.sv
verification/memModel.sv
verification/dataCacheTb.sv

// File: run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f tb.f --top-module dataCacheTb -Mdir obj_dir -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
